/* source/der_settings.svh */
// Drawing engine register block widths and host register word addresses
`ifndef DER_SETTINGS_SVH
`define DER_SETTINGS_SVH

//////////////////////////////////////////////////
// Field widths
//////////////////////////////////////////////////
`define DER_DATA_W        32      // Host data bus
`define DER_ADDR_W        4       // Register word address
`define DER_PTCH_W        12      // Source and destination pitch
`define DER_BCTRL_W       12      // Buffer control
`define DER_STYLE_W       5       // Drawing style

//////////////////////////////////////////////////
// Register word addresses
//////////////////////////////////////////////////
`define DER_ADR_BUF_CTRL  4'd0
`define DER_ADR_SORG      4'd1    // Source origin
`define DER_ADR_DORG      4'd2    // Destination origin
`define DER_ADR_PTCH      4'd3    // Sptch in 11:0, dptch in 27:16
`define DER_ADR_CMD       4'd4    // Opc 3:0, rop 7:4, style 12:8
`define DER_ADR_FORE      4'd5    // Foreground color
`define DER_ADR_BACK      4'd6    // Background color
`define DER_ADR_MASK      4'd7    // Plane mask in 3:0
`define DER_ADR_XY0       4'd8
`define DER_ADR_XY1       4'd9    // Write here triggers the command
`define DER_ADR_STATUS    4'd15   // Read only, bit 0 pending, bit 1 busy

`endif

/* source/der_reg_pkg.sv */
// Register field types of the drawing engine register block
`include "der_settings.svh"

package der_reg_pkg;

  //////////////////////////////////////////////////
  // Host bus types
  //////////////////////////////////////////////////
  typedef logic [`DER_DATA_W-1:0]     der_word_t;   // Host data word
  typedef logic [`DER_ADDR_W-1:0]     der_addr_t;   // Register word address
  typedef logic [`DER_DATA_W/8-1:0]   der_ben_t;    // One enable per byte

  //////////////////////////////////////////////////
  // Drawing field types
  //////////////////////////////////////////////////
  typedef logic [`DER_PTCH_W-1:0]     der_ptch_t;   // Pitch in bytes
  typedef logic [`DER_BCTRL_W-1:0]    der_bctrl_t;  // Buffer control bits
  typedef logic [3:0]                 der_rop_t;    // Raster op code
  typedef logic [`DER_STYLE_W-1:0]    der_style_t;  // Drawing style bits
  typedef logic [3:0]                 der_mask_t;   // Plane mask

endpackage

/* source/der_cmd_pkg.sv */
// Drawing command opcodes and dispatcher state encoding

package der_cmd_pkg;

  typedef logic [3:0] der_opc_t;            // Drawing opcode

  // Opcodes understood by the 2D engine
  localparam der_opc_t OPC_NOOP = 4'h0;     // Load only, no start
  localparam der_opc_t OPC_LINE = 4'h1;     // Start a line
  localparam der_opc_t OPC_BLT  = 4'h2;     // Start a BLT

  //////////////////////////////////////////////////
  // Dispatcher states
  //////////////////////////////////////////////////
  typedef enum logic [1:0] {
    DISP_IDLE = 2'd0,                       // Wait for pending and engine idle
    DISP_LOAD = 2'd1,                       // Copy level one into active set
    DISP_GO   = 2'd2                        // Issue the start pulse
  } der_disp_state_t;

endpackage

/* source/der_host_regs.sv */
// Level-one drawing registers with byte-enable host writes and command trigger
`include "der_settings.svh"

module der_host_regs (
  input  logic                     de_clk,
  input  logic                     rst,
  input  logic                     hb_valid,     // Host request
  input  logic                     hb_we,        // Write request when high
  input  der_reg_pkg::der_addr_t   hb_adr,
  input  der_reg_pkg::der_ben_t    hb_ben,
  input  der_reg_pkg::der_word_t   hb_din,
  input  logic                     cmd_ack,      // Dispatcher took the command
  output logic                     hb_ready,
  output logic                     cmd_pending,
  output der_reg_pkg::der_bctrl_t  buf_ctrl_1,
  output der_reg_pkg::der_word_t   sorg_1,
  output der_reg_pkg::der_word_t   dorg_1,
  output der_reg_pkg::der_word_t   fore_1,
  output der_reg_pkg::der_word_t   back_1,
  output der_reg_pkg::der_word_t   xy0_1,
  output der_reg_pkg::der_word_t   xy1_1,
  output der_reg_pkg::der_ptch_t   sptch_1,
  output der_reg_pkg::der_ptch_t   dptch_1,
  output der_cmd_pkg::der_opc_t    opc_1,
  output der_reg_pkg::der_rop_t    rop_1,
  output der_reg_pkg::der_style_t  style_1,
  output der_reg_pkg::der_mask_t   mask_1
);
  import der_reg_pkg::*;

  logic      wr_en;                              // Accepted host write
  logic      trig_q;                             // XY1 written last cycle
  der_word_t bctrl_w;                            // Merged buffer control word
  der_word_t ptch_w;                             // Merged pitch word
  der_word_t cmd_w;                              // Merged command word
  der_word_t mask_w;                             // Merged mask word

  // Replace only the enabled bytes of a register word
  function automatic der_word_t bmerge(input der_word_t old, input der_word_t din,
                                       input der_ben_t ben);
    der_word_t res;
    for (int i = 0; i < $bits(der_ben_t); i++) begin
      res[8*i +: 8] = ben[i] ? din[8*i +: 8] : old[8*i +: 8];
    end
    return res;
  endfunction

  assign hb_ready = ~cmd_pending;                // Stall host while a command waits
  assign wr_en    = hb_valid & hb_ready & hb_we;

  // Packed fields seen as full words for the byte merge
  assign bctrl_w = bmerge(der_word_t'(buf_ctrl_1), hb_din, hb_ben);
  assign ptch_w  = bmerge({4'h0, dptch_1, 4'h0, sptch_1}, hb_din, hb_ben);
  assign cmd_w   = bmerge(der_word_t'({style_1, rop_1, opc_1}), hb_din, hb_ben);
  assign mask_w  = bmerge(der_word_t'(mask_1), hb_din, hb_ben);

  //////////////////////////////////////////////////
  // Register writes and pending flag
  //////////////////////////////////////////////////
  always_ff @(posedge de_clk) begin
    if (rst) begin
      trig_q      <= 1'b0;
      cmd_pending <= 1'b0;
      buf_ctrl_1  <= '0;
      sorg_1      <= '0;
      dorg_1      <= '0;
      fore_1      <= '0;
      back_1      <= '0;
      xy0_1       <= '0;
      xy1_1       <= '0;
      sptch_1     <= '0;
      dptch_1     <= '0;
      opc_1       <= '0;
      rop_1       <= '0;
      style_1     <= '0;
      mask_1      <= '0;
    end else begin
      trig_q <= wr_en && (hb_adr == `DER_ADR_XY1);    // Trigger seen one cycle late
      if (trig_q) begin
        cmd_pending <= 1'b1;
      end else if (cmd_ack) begin
        cmd_pending <= 1'b0;                          // Level one now free again
      end
      if (wr_en) begin
        case (hb_adr)
          `DER_ADR_BUF_CTRL: buf_ctrl_1 <= bctrl_w[`DER_BCTRL_W-1:0];
          `DER_ADR_SORG:     sorg_1     <= bmerge(sorg_1, hb_din, hb_ben);
          `DER_ADR_DORG:     dorg_1     <= bmerge(dorg_1, hb_din, hb_ben);
          `DER_ADR_PTCH: begin
            sptch_1 <= ptch_w[`DER_PTCH_W-1:0];       // Low half
            dptch_1 <= ptch_w[16 +: `DER_PTCH_W];     // High half
          end
          `DER_ADR_CMD: begin
            opc_1   <= cmd_w[3:0];
            rop_1   <= cmd_w[7:4];
            style_1 <= cmd_w[8 +: `DER_STYLE_W];
          end
          `DER_ADR_FORE:     fore_1     <= bmerge(fore_1, hb_din, hb_ben);
          `DER_ADR_BACK:     back_1     <= bmerge(back_1, hb_din, hb_ben);
          `DER_ADR_MASK:     mask_1     <= mask_w[3:0];
          `DER_ADR_XY0:      xy0_1      <= bmerge(xy0_1, hb_din, hb_ben);
          `DER_ADR_XY1:      xy1_1      <= bmerge(xy1_1, hb_din, hb_ben);
          default: ;                                  // Unmapped or read only
        endcase
      end
    end
  end

endmodule

/* source/der_active_regs.sv */
// Second-level active drawing registers loaded from level one per command

module der_active_regs (
  input  logic                     de_clk,
  input  logic                     rst,
  input  logic                     load_actv,    // Copy level one this cycle
  input  der_reg_pkg::der_bctrl_t  buf_ctrl_1,
  input  der_reg_pkg::der_word_t   sorg_1,
  input  der_reg_pkg::der_word_t   dorg_1,
  input  der_reg_pkg::der_word_t   fore_1,
  input  der_reg_pkg::der_word_t   back_1,
  input  der_reg_pkg::der_word_t   xy0_1,
  input  der_reg_pkg::der_word_t   xy1_1,
  input  der_reg_pkg::der_ptch_t   sptch_1,
  input  der_reg_pkg::der_ptch_t   dptch_1,
  input  der_cmd_pkg::der_opc_t    opc_1,
  input  der_reg_pkg::der_rop_t    rop_1,
  input  der_reg_pkg::der_style_t  style_1,
  input  der_reg_pkg::der_mask_t   mask_1,
  output der_reg_pkg::der_bctrl_t  buf_ctrl_2,
  output der_reg_pkg::der_word_t   sorg_2,
  output der_reg_pkg::der_word_t   dorg_2,
  output der_reg_pkg::der_word_t   fore_2,
  output der_reg_pkg::der_word_t   back_2,
  output der_reg_pkg::der_word_t   xy0_2,
  output der_reg_pkg::der_word_t   xy1_2,
  output der_reg_pkg::der_ptch_t   sptch_2,
  output der_reg_pkg::der_ptch_t   dptch_2,
  output der_cmd_pkg::der_opc_t    opc_2,
  output der_reg_pkg::der_rop_t    rop_2,
  output der_reg_pkg::der_style_t  style_2,
  output der_reg_pkg::der_mask_t   mask_2
);

  // Whole set moves at once so the engine never sees a mixed command
  always_ff @(posedge de_clk) begin
    if (rst) begin
      {buf_ctrl_2, sorg_2, dorg_2, fore_2, back_2, xy0_2, xy1_2} <= '0;
      {sptch_2, dptch_2, opc_2, rop_2, style_2, mask_2}         <= '0;
    end else if (load_actv) begin
      {buf_ctrl_2, sorg_2, dorg_2, fore_2, back_2, xy0_2, xy1_2} <=
        {buf_ctrl_1, sorg_1, dorg_1, fore_1, back_1, xy0_1, xy1_1};
      {sptch_2, dptch_2, opc_2, rop_2, style_2, mask_2} <=
        {sptch_1, dptch_1, opc_1, rop_1, style_1, mask_1};
    end
  end

endmodule

/* source/der_dispatch.sv */
// Command dispatcher issuing the active load and 2D start pulses

module der_dispatch (
  input  logic                   de_clk,
  input  logic                   rst,
  input  logic                   cmd_pending,    // Level one holds a command
  input  logic                   dex_busy,       // 2D engine still drawing
  input  der_cmd_pkg::der_opc_t  opc_1,
  output logic                   load_actv,      // Copy level one to active set
  output logic                   cmd_ack,        // Clears the pending flag
  output logic                   goline,
  output logic                   goblt,
  output logic                   disp_busy
);
  import der_cmd_pkg::*;

  der_disp_state_t state;
  der_disp_state_t state_nxt;
  der_opc_t        opc_q;                        // Opcode of the loaded command

  //////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////
  always_comb begin
    state_nxt = state;
    case (state)
      DISP_IDLE: begin
        if (cmd_pending && !dex_busy) begin
          state_nxt = DISP_LOAD;                 // Engine free, take command
        end
      end
      DISP_LOAD: state_nxt = DISP_GO;
      DISP_GO:   state_nxt = DISP_IDLE;
      default:   state_nxt = DISP_IDLE;
    endcase
  end

  always_ff @(posedge de_clk) begin
    if (rst) begin
      state <= DISP_IDLE;
      opc_q <= OPC_NOOP;
    end else begin
      state <= state_nxt;
      if (state == DISP_LOAD) begin
        opc_q <= opc_1;                          // Same edge as active set load
      end
    end
  end

  //////////////////////////////////////////////////
  // Pulse outputs
  //////////////////////////////////////////////////
  assign load_actv = (state == DISP_LOAD);
  assign cmd_ack   = load_actv;
  assign goline    = (state == DISP_GO) && (opc_q == OPC_LINE);
  assign goblt     = (state == DISP_GO) && (opc_q == OPC_BLT);   // Others act as noop
  assign disp_busy = (state != DISP_IDLE);

endmodule

/* source/der_rdmux.sv */
// Registered host read-back mux for level-one registers and status
`include "der_settings.svh"

module der_rdmux (
  input  logic                     de_clk,
  input  logic                     rst,
  input  logic                     hb_valid,
  input  logic                     hb_we,
  input  logic                     hb_ready,
  input  der_reg_pkg::der_addr_t   hb_adr,
  input  der_reg_pkg::der_bctrl_t  buf_ctrl_1,
  input  der_reg_pkg::der_word_t   sorg_1,
  input  der_reg_pkg::der_word_t   dorg_1,
  input  der_reg_pkg::der_word_t   fore_1,
  input  der_reg_pkg::der_word_t   back_1,
  input  der_reg_pkg::der_word_t   xy0_1,
  input  der_reg_pkg::der_word_t   xy1_1,
  input  der_reg_pkg::der_ptch_t   sptch_1,
  input  der_reg_pkg::der_ptch_t   dptch_1,
  input  der_cmd_pkg::der_opc_t    opc_1,
  input  der_reg_pkg::der_rop_t    rop_1,
  input  der_reg_pkg::der_style_t  style_1,
  input  der_reg_pkg::der_mask_t   mask_1,
  input  logic                     cmd_pending,
  input  logic                     disp_busy,
  output logic                     hb_rvalid,    // One cycle after read accept
  output der_reg_pkg::der_word_t   hb_dout
);
  import der_reg_pkg::*;

  logic      rd_en;                              // Accepted host read
  der_word_t rd_sel;                             // Addressed register word

  assign rd_en = hb_valid & hb_ready & ~hb_we;

  always_comb begin
    case (hb_adr)
      `DER_ADR_BUF_CTRL: rd_sel = der_word_t'(buf_ctrl_1);
      `DER_ADR_SORG:     rd_sel = sorg_1;
      `DER_ADR_DORG:     rd_sel = dorg_1;
      `DER_ADR_PTCH:     rd_sel = {4'h0, dptch_1, 4'h0, sptch_1};
      `DER_ADR_CMD:      rd_sel = der_word_t'({style_1, rop_1, opc_1});
      `DER_ADR_FORE:     rd_sel = fore_1;
      `DER_ADR_BACK:     rd_sel = back_1;
      `DER_ADR_MASK:     rd_sel = der_word_t'(mask_1);
      `DER_ADR_XY0:      rd_sel = xy0_1;
      `DER_ADR_XY1:      rd_sel = xy1_1;
      `DER_ADR_STATUS:   rd_sel = der_word_t'({disp_busy, cmd_pending});
      default:           rd_sel = '0;          // Unmapped reads as zero
    endcase
  end

  always_ff @(posedge de_clk) begin
    if (rst) begin
      hb_rvalid <= 1'b0;
      hb_dout   <= '0;
    end else begin
      hb_rvalid <= rd_en;
      if (rd_en) begin
        hb_dout <= rd_sel;                       // Held until the next read
      end
    end
  end

endmodule

/* source/der_top.sv */
// Drawing engine register block top with host port and 2D command dispatch

module der_top (
  input  logic                     de_clk,
  input  logic                     rst,
  input  logic                     hb_valid,
  input  logic                     hb_we,
  input  der_reg_pkg::der_addr_t   hb_adr,
  input  der_reg_pkg::der_ben_t    hb_ben,
  input  der_reg_pkg::der_word_t   hb_din,
  input  logic                     dex_busy,     // 2D engine busy
  output logic                     hb_ready,
  output logic                     hb_rvalid,
  output der_reg_pkg::der_word_t   hb_dout,
  output logic                     goline,       // Start 2D line
  output logic                     goblt,        // Start 2D BLT
  output logic                     load_actv,    // Active set loaded
  output der_cmd_pkg::der_opc_t    opc_2,
  output der_reg_pkg::der_rop_t    rop_2,
  output der_reg_pkg::der_style_t  style_2,
  output der_reg_pkg::der_bctrl_t  buf_ctrl_2,
  output der_reg_pkg::der_word_t   sorg_2,
  output der_reg_pkg::der_word_t   dorg_2,
  output der_reg_pkg::der_ptch_t   sptch_2,
  output der_reg_pkg::der_ptch_t   dptch_2,
  output der_reg_pkg::der_word_t   fore_2,
  output der_reg_pkg::der_word_t   back_2,
  output der_reg_pkg::der_mask_t   mask_2,
  output der_reg_pkg::der_word_t   xy0_2,
  output der_reg_pkg::der_word_t   xy1_2
);
  import der_reg_pkg::*;
  import der_cmd_pkg::*;

  logic       cmd_pending;                       // Level one waits for dispatch
  logic       cmd_ack;                           // Dispatcher took the command
  logic       disp_busy;                         // Dispatcher outside idle
  der_bctrl_t buf_ctrl_1;
  der_word_t  sorg_1, dorg_1, fore_1, back_1, xy0_1, xy1_1;
  der_ptch_t  sptch_1, dptch_1;
  der_opc_t   opc_1;
  der_rop_t   rop_1;
  der_style_t style_1;
  der_mask_t  mask_1;

  //////////////////////////////////////////////////
  // Register file beside the dispatcher it steers
  //////////////////////////////////////////////////
  der_host_regs   u_der_host_regs   (.*);
  der_dispatch    u_der_dispatch    (.*);
  der_active_regs u_der_active_regs (.*);
  der_rdmux       u_der_rdmux       (.*);        // Host read-back path

endmodule

/* bench/der_top_properties.sv */
// Concurrent checks on command dispatch timing and active register transfer
`include "der_settings.svh"

module der_top_properties (
  input logic                     de_clk, rst, dex_busy,
  input logic                     load_actv, goline, goblt,
  input der_reg_pkg::der_bctrl_t  buf_ctrl_1, buf_ctrl_2,
  input der_reg_pkg::der_word_t   sorg_1, dorg_1, fore_1, back_1, xy0_1, xy1_1,
  input der_reg_pkg::der_word_t   sorg_2, dorg_2, fore_2, back_2, xy0_2, xy1_2,
  input der_reg_pkg::der_ptch_t   sptch_1, dptch_1, sptch_2, dptch_2,
  input der_cmd_pkg::der_opc_t    opc_1, opc_2,
  input der_reg_pkg::der_rop_t    rop_1, rop_2,
  input der_reg_pkg::der_style_t  style_1, style_2,
  input der_reg_pkg::der_mask_t   mask_1, mask_2
);
  timeunit 1ns;
  timeprecision 1ps;
  import der_cmd_pkg::*;

  localparam int SET_W = `DER_BCTRL_W + 6*`DER_DATA_W + 2*`DER_PTCH_W + 17;

  int               fail_cnt = 0;               // Failed assertion count
  logic [SET_W-1:0] set_1;                      // Whole level-one set
  logic [SET_W-1:0] set_2;                      // Whole active set

  assign set_1 = {buf_ctrl_1, sorg_1, dorg_1, sptch_1, dptch_1, style_1, rop_1, opc_1,
                  fore_1, back_1, mask_1, xy0_1, xy1_1};
  assign set_2 = {buf_ctrl_2, sorg_2, dorg_2, sptch_2, dptch_2, style_2, rop_2, opc_2,
                  fore_2, back_2, mask_2, xy0_2, xy1_2};

  //////////////////////////////////////////////////
  // Dispatch order
  //////////////////////////////////////////////////
  a_go_after_load: assert property (@(posedge de_clk) disable iff (rst)
      load_actv |=> (goline == (opc_2 == OPC_LINE)) && (goblt == (opc_2 == OPC_BLT)))
    else begin
      fail_cnt++;
      $error("start pulse after load does not match the loaded opcode");
    end
  a_go_needs_load: assert property (@(posedge de_clk) disable iff (rst)
      (goline || goblt) |-> $past(load_actv))      // Start only right after a load
    else begin
      fail_cnt++;
      $error("start pulse without a load in the cycle before");
    end
  a_no_load_busy: assert property (@(posedge de_clk) disable iff (rst)
      load_actv |-> !$past(dex_busy))
    else begin
      fail_cnt++;
      $error("active set loaded while the engine was busy");
    end

  //////////////////////////////////////////////////
  // Active set transfer
  //////////////////////////////////////////////////
  a_transfer: assert property (@(posedge de_clk) disable iff (rst)
      load_actv |=> (set_2 == $past(set_1)))
    else begin
      fail_cnt++;
      $error("active set differs from level one after load");
    end
  a_stable: assert property (@(posedge de_clk) disable iff (rst)
      !load_actv |=> $stable(set_2))                // Only a load may change it
    else begin
      fail_cnt++;
      $error("active set changed without a load");
    end

endmodule

bind der_top der_top_properties u_der_top_properties (.*);

/* bench/der_top_tb.sv */
// Testbench for the drawing register block with host tasks and engine model
`include "der_settings.svh"

module der_top_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import der_reg_pkg::*;
  import der_cmd_pkg::*;

  localparam int TMO   = 50;                    // Wait limit in cycles
  localparam int ACT_W = `DER_BCTRL_W + 6*`DER_DATA_W + 2*`DER_PTCH_W + 17;
  typedef logic [ACT_W-1:0] act_set_t;          // Whole active set as one vector

  logic       de_clk = 1'b0;
  logic       rst;
  logic       hb_valid;
  logic       hb_we;
  der_addr_t  hb_adr;
  der_ben_t   hb_ben;
  der_word_t  hb_din;
  logic       eng_busy = 1'b0;                  // Engine model after a start
  logic       hold_busy = 1'b0;                 // Forced stall for back-pressure
  wire        dex_busy = eng_busy | hold_busy;
  logic       hb_ready, hb_rvalid, goline, goblt, load_actv;
  der_word_t  hb_dout;
  der_opc_t   opc_2;
  der_rop_t   rop_2;
  der_style_t style_2;
  der_bctrl_t buf_ctrl_2;
  der_ptch_t  sptch_2, dptch_2;
  der_mask_t  mask_2;
  der_word_t  sorg_2, dorg_2, fore_2, back_2, xy0_2, xy1_2;

  integer     seed = 79388;
  der_word_t  regs_exp [16];                    // Expected level-one read values
  act_set_t   snap;
  der_addr_t  adr;
  der_ben_t   ben;
  der_word_t  rd;
  int         test_err, prop_base, n_pass, n_fail;

  der_top u_der_top (.*);

  always #10 de_clk = ~de_clk;                  // 20 ns period

  // Engine model, busy 2 to 6 cycles per start
  always begin
    @(negedge de_clk);
    if (goline || goblt) begin
      eng_busy <= 1'b1;
      repeat (2 + {$random(seed)} % 5) @(negedge de_clk);
      eng_busy <= 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////
  function automatic der_word_t field_mask(input der_addr_t a);
    case (a)
      `DER_ADR_BUF_CTRL: return 32'h0000_0fff;
      `DER_ADR_PTCH:     return 32'h0fff_0fff;    // Two 12 bit pitches
      `DER_ADR_CMD:      return 32'h0000_1fff;    // Opc, rop, style
      `DER_ADR_MASK:     return 32'h0000_000f;
      `DER_ADR_SORG, `DER_ADR_DORG, `DER_ADR_FORE, `DER_ADR_BACK,
      `DER_ADR_XY0, `DER_ADR_XY1: return 32'hffff_ffff;
      default:           return 32'h0;            // Unmapped and status
    endcase
  endfunction

  function automatic der_word_t replace_bytes(input der_word_t old, input der_word_t din,
                                              input der_ben_t be);
    der_word_t keep;
    keep = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    return (old & ~keep) | (din & keep);
  endfunction

  function automatic act_set_t active_exp();
    return {regs_exp[0][11:0], regs_exp[1], regs_exp[2], regs_exp[3][11:0],
            regs_exp[3][27:16], regs_exp[4][12:0], regs_exp[5], regs_exp[6],
            regs_exp[7][3:0], regs_exp[8], regs_exp[9]};
  endfunction

  function automatic act_set_t active_now();
    return {buf_ctrl_2, sorg_2, dorg_2, sptch_2, dptch_2, style_2, rop_2, opc_2,
            fore_2, back_2, mask_2, xy0_2, xy1_2};
  endfunction

  //////////////////////////////////////////////////
  // Checks and host tasks
  //////////////////////////////////////////////////
  task automatic check_value(input string name, input act_set_t exp, input act_set_t act);
    assert (act === exp) else begin
      $display("** Error %s: expected %0h, actual %0h", name, exp, act);
      test_err++;
    end
  endtask

  task automatic abort_run(input string what);
    $display("Timeout: %s", what);
    $display("SOME TESTS FAILED");
    $finish;
  endtask

  task automatic host_xfer(input logic we, input der_addr_t a, input der_ben_t be,
                           input der_word_t din, output der_word_t dout);
    int n;
    @(negedge de_clk);
    hb_valid = 1'b1;
    hb_we    = we;
    hb_adr   = a;
    hb_ben   = be;
    hb_din   = din;
    n = 0;
    while (!hb_ready && n < TMO) begin          // Request held while stalled
      @(negedge de_clk);
      n++;
    end
    if (!hb_ready) abort_run("host port never became ready");
    @(negedge de_clk);                          // Accepted on the edge just passed
    hb_valid = 1'b0;
    n = 0;
    while (!we && !hb_rvalid && n < TMO) begin
      @(negedge de_clk);
      n++;
    end
    if (!we && !hb_rvalid) abort_run("read data never returned");
    dout = hb_dout;
  endtask

  task automatic write_reg(input der_addr_t a, input der_ben_t be, input der_word_t din);
    der_word_t unused;
    host_xfer(1'b1, a, be, din, unused);
    regs_exp[a] = replace_bytes(regs_exp[a], din, be) & field_mask(a);
  endtask

  task automatic read_check(input string name, input der_addr_t a, input der_word_t exp);
    der_word_t got;
    host_xfer(1'b0, a, '0, '0, got);
    check_value(name, act_set_t'(exp), act_set_t'(got));
  endtask

  task automatic wait_load();
    int n;
    n = 0;
    do begin
      @(negedge de_clk);
      n++;
    end while (!load_actv && n < TMO);
    if (!load_actv) abort_run("no active load after trigger");
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    do begin
      @(negedge de_clk);
      n++;
    end while ((dex_busy || !hb_ready) && n < TMO);
    if (dex_busy || !hb_ready) abort_run("engine or host port stayed busy");
  endtask

  // Fill level one with random values, then trigger through XY1
  task automatic issue_command(input der_opc_t opc);
    for (int a = 0; a < `DER_ADR_XY1; a++) begin
      write_reg(der_addr_t'(a), 4'hf, $random(seed));
    end
    write_reg(`DER_ADR_CMD, 4'hf, ({$random(seed)} & 32'hffff_fff0) | opc);
    write_reg(`DER_ADR_XY1, 4'hf, $random(seed));
  endtask

  task automatic run_command(input string name, input der_opc_t opc, input logic [1:0] go);
    issue_command(opc);
    wait_load();
    @(negedge de_clk);                          // GO cycle right after the load
    check_value({name, " start"}, act_set_t'(go), act_set_t'({goline, goblt}));
    check_value({name, " active"}, active_exp(), active_now());
    wait_idle();
  endtask

  task automatic start_test();
    test_err  = 0;
    prop_base = u_der_top.u_der_top_properties.fail_cnt;
  endtask

  task automatic end_test(input string name);
    int errs;
    errs = test_err + u_der_top.u_der_top_properties.fail_cnt - prop_base;
    if (errs == 0) begin
      n_pass++;
    end else begin
      n_fail++;
    end
    $display("test %s: %s (%0d errors)", name, (errs == 0) ? "PASS" : "FAIL", errs);
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////
  initial begin
    rst      = 1'b1;
    hb_valid = 1'b0;
    hb_we    = 1'b0;
    hb_adr   = '0;
    hb_ben   = '0;
    hb_din   = '0;
    n_pass   = 0;
    n_fail   = 0;
    foreach (regs_exp[i]) regs_exp[i] = '0;
    repeat (2) @(negedge de_clk);               // Two reset cycles
    rst = 1'b0;

    start_test();
    check_value("reset ready", 1'b1, hb_ready);
    check_value("reset pulses", 3'b000, {goline, goblt, load_actv});
    for (int a = 0; a < 16; a++) read_check("reset read", der_addr_t'(a), 32'h0);
    end_test("reset");

    start_test();
    for (int i = 0; i < 24; i++) begin
      adr = der_addr_t'({$random(seed)} % 9);   // XY1 left out, it triggers
      ben = der_ben_t'($random(seed));
      write_reg(adr, ben, $random(seed));
      read_check("byte enable", adr, regs_exp[adr]);
    end
    for (int a = 10; a < 15; a++) begin
      write_reg(der_addr_t'(a), 4'hf, $random(seed));
      read_check("unmapped", der_addr_t'(a), 32'h0);
    end
    end_test("byte_enable");

    start_test();
    run_command("line", OPC_LINE, 2'b10);
    run_command("blt", OPC_BLT, 2'b01);
    end_test("dispatch");

    start_test();
    run_command("noop", OPC_NOOP, 2'b00);
    run_command("undefined", 4'hb, 2'b00);      // Unknown opcode acts as noop
    end_test("noop");

    start_test();
    hold_busy = 1'b1;
    issue_command(OPC_BLT);
    repeat (4) begin
      @(negedge de_clk);
      check_value("stall load", 1'b0, load_actv);
    end
    check_value("stall ready", 1'b0, hb_ready);
    hold_busy = 1'b0;
    host_xfer(1'b0, `DER_ADR_STATUS, '0, '0, rd);
    check_value("status pending", 1'b0, rd[0]);
    check_value("status busy", 1'b1, rd[1]);    // Read lands in the GO cycle
    check_value("stall active", active_exp(), active_now());
    wait_idle();
    end_test("backpressure");

    start_test();
    run_command("stable", OPC_LINE, 2'b10);
    snap = active_now();
    for (int a = 0; a < `DER_ADR_XY1; a++) begin
      write_reg(der_addr_t'(a), der_ben_t'($random(seed)), $random(seed));
    end
    check_value("held active", snap, active_now());
    run_command("reload", OPC_BLT, 2'b01);
    end_test("active_stable");

    $display("%0d tests run, %0d passed, %0d failed", n_pass + n_fail, n_pass, n_fail);
    if (n_fail == 0 && u_der_top.u_der_top_properties.fail_cnt == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* der_top.f */
+incdir+source
source/der_reg_pkg.sv
source/der_cmd_pkg.sv
source/der_host_regs.sv
source/der_active_regs.sv
source/der_dispatch.sv
source/der_rdmux.sv
source/der_top.sv
bench/der_top_properties.sv
bench/der_top_tb.sv

/* Bender.yml */
package:
  name: der_top

sources:
  - include_dirs:
      - source
    files:
      - source/der_reg_pkg.sv
      - source/der_cmd_pkg.sv
      - source/der_host_regs.sv
      - source/der_active_regs.sv
      - source/der_dispatch.sv
      - source/der_rdmux.sv
      - source/der_top.sv
      - bench/der_top_properties.sv
      - bench/der_top_tb.sv
